//--- rtl/core_config_pkg.sv
// shared widths, operation encodings and stage structs, imported by every module of the slice
package core_config_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int XLEN       = 32;  // data path width
    localparam int REG_ADDR_W = 5;   // register index width
    localparam int NUM_REGS   = 1 << REG_ADDR_W;

    // ==================================================
    // operation encodings
    // ==================================================
    typedef enum logic [4:0] {
        i_NOP,
        i_ADD, i_SUB, i_AND, i_OR, i_XOR,
        i_SLL, i_SRL, i_SRA, i_SLT, i_SLTU,
        i_ADDI, i_ANDI, i_ORI, i_XORI,
        i_SLLI, i_SRLI, i_SRAI, i_SLTI, i_SLTIU
    } opcodes_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_commands_t;

    // ==================================================
    // stage structs
    // ==================================================
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;      // sign-extended immediate or shift amount
        opcodes_t              opcode;
        logic                  illegal;  // not an OP or OP-IMM encoding
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0]       arg0;
        logic [XLEN-1:0]       arg1;     // second register or immediate
        alu_commands_t         cmd;
        logic [REG_ADDR_W-1:0] rd;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

//--- rtl/decoder.sv
// decode stage that latches one raw RV32I arithmetic instruction and splits it into fields
module decoder (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [core_config_pkg::XLEN-1:0] instr,
    input  logic                             instr_valid,
    input  logic                             dec_busy,
    output core_config_pkg::decoded_t        dec,
    output logic                             dec_valid
);
    import core_config_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic [XLEN-1:0] r_instr;
    logic            r_valid;
    logic [6:0]      funct7;
    logic [2:0]      funct3;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (!dec_busy) begin
            r_valid <= instr_valid;  // output holds while the issuer stalls
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid && !dec_busy) begin
            r_instr <= instr;
        end
    end

    assign dec_valid = r_valid;
    assign funct7    = r_instr[31:25];
    assign funct3    = r_instr[14:12];

    // ==================================================
    // field decode
    // ==================================================
    always_comb begin
        dec     = '0;
        dec.rs1 = r_instr[19:15];
        dec.rs2 = r_instr[24:20];
        dec.rd  = r_instr[11:7];
        case (r_instr[6:0])
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec.opcode = i_ADD;
                    {7'h20, 3'b000}: dec.opcode = i_SUB;
                    {7'h00, 3'b001}: dec.opcode = i_SLL;
                    {7'h00, 3'b010}: dec.opcode = i_SLT;
                    {7'h00, 3'b011}: dec.opcode = i_SLTU;
                    {7'h00, 3'b100}: dec.opcode = i_XOR;
                    {7'h00, 3'b101}: dec.opcode = i_SRL;
                    {7'h20, 3'b101}: dec.opcode = i_SRA;
                    {7'h00, 3'b110}: dec.opcode = i_OR;
                    {7'h00, 3'b111}: dec.opcode = i_AND;
                    default:         dec.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                dec.imm = {{(XLEN-12){r_instr[31]}}, r_instr[31:20]};
                case (funct3)
                    3'b000:  dec.opcode = i_ADDI;
                    3'b010:  dec.opcode = i_SLTI;
                    3'b011:  dec.opcode = i_SLTIU;
                    3'b100:  dec.opcode = i_XORI;
                    3'b110:  dec.opcode = i_ORI;
                    3'b111:  dec.opcode = i_ANDI;
                    default: begin
                        // shifts carry only the shift amount, funct7 selects the kind
                        dec.imm = {{(XLEN-5){1'b0}}, r_instr[24:20]};
                        if (funct7 == 7'h00) begin
                            dec.opcode = (funct3 == 3'b001) ? i_SLLI : i_SRLI;
                        end else if (funct7 == 7'h20 && funct3 == 3'b101) begin
                            dec.opcode = i_SRAI;
                        end else begin
                            dec.illegal = 1'b1;
                        end
                    end
                endcase
            end
            default: dec.illegal = 1'b1;  // loads, stores, branches and the rest
        endcase
    end

endmodule

//--- rtl/issuer.sv
// issue stage that holds one decoded instruction, resolves hazards and bypass, and starts an ALU
module issuer #(
    parameter int NUM_ALU = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  core_config_pkg::decoded_t              dec,
    input  logic                                   dec_valid,
    output logic                                   dec_busy,
    output logic                                   occupancy_lock,
    output logic [core_config_pkg::REG_ADDR_W-1:0] occupancy_rd,
    input  logic [core_config_pkg::NUM_REGS-1:0]   occupancy_busy,
    output logic [core_config_pkg::REG_ADDR_W-1:0] reg_ra0,
    output logic [core_config_pkg::REG_ADDR_W-1:0] reg_ra1,
    input  logic [core_config_pkg::XLEN-1:0]       reg_rd0,
    input  logic [core_config_pkg::XLEN-1:0]       reg_rd1,
    input  core_config_pkg::wb_t [NUM_ALU-1:0]     bypass,
    output logic [NUM_ALU-1:0]                     alu_start,
    output core_config_pkg::issue_t                alu_issue,
    input  logic [NUM_ALU-1:0]                     alu_busy,
    output logic                                   illegal
);
    import core_config_pkg::*;

    decoded_t            r_instr;
    logic                r_full;
    logic                uses_rs2;
    logic [NUM_REGS-1:0] released;
    logic [NUM_REGS-1:0] locked;
    logic                hazard;
    logic [NUM_ALU-1:0]  free_alu;
    logic                can_issue;
    logic                leave;
    logic [XLEN-1:0]     op_a;
    logic [XLEN-1:0]     op_b;
    alu_commands_t       cmd;

    // ==================================================
    // waiting stage
    // ==================================================
    assign leave    = can_issue | (r_full & r_instr.illegal);  // illegal ones drop out at once
    assign dec_busy = r_full & ~leave;
    assign illegal  = r_full & r_instr.illegal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_full <= 1'b0;
        end else if (!dec_busy) begin
            r_full <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && !dec_busy) begin
            r_instr <= dec;
        end
    end

    // ==================================================
    // bypass and hazard check
    // ==================================================
    always_comb begin
        released = '0;
        op_a     = reg_rd0;
        op_b     = reg_rd1;
        for (int i = 0; i < NUM_ALU; i++) begin
            if (bypass[i].valid) begin
                released[bypass[i].rd] = 1'b1;  // lock ends at this edge
                if (bypass[i].rd == r_instr.rs1 && r_instr.rs1 != '0) begin
                    op_a = bypass[i].data;
                end
                if (bypass[i].rd == r_instr.rs2 && r_instr.rs2 != '0) begin
                    op_b = bypass[i].data;
                end
            end
        end
    end

    assign uses_rs2  = r_instr.opcode inside {i_ADD, i_SUB, i_AND, i_OR, i_XOR,
                                              i_SLL, i_SRL, i_SRA, i_SLT, i_SLTU};
    assign locked    = occupancy_busy & ~released;
    assign hazard    = locked[r_instr.rs1] | (uses_rs2 & locked[r_instr.rs2]) | locked[r_instr.rd];
    assign free_alu  = ~alu_busy;
    assign can_issue = r_full & ~r_instr.illegal & ~hazard & (|free_alu);

    always_comb begin
        case (r_instr.opcode)
            i_SUB:          cmd = ALU_SUB;
            i_AND, i_ANDI:  cmd = ALU_AND;
            i_OR, i_ORI:    cmd = ALU_OR;
            i_XOR, i_XORI:  cmd = ALU_XOR;
            i_SLL, i_SLLI:  cmd = ALU_SLL;
            i_SRL, i_SRLI:  cmd = ALU_SRL;
            i_SRA, i_SRAI:  cmd = ALU_SRA;
            i_SLT, i_SLTI:  cmd = ALU_SLT;
            i_SLTU, i_SLTIU: cmd = ALU_SLTU;
            default:        cmd = ALU_ADD;  // add, addi and nop
        endcase
    end

    // ==================================================
    // dispatch
    // ==================================================
    assign alu_start      = can_issue ? (free_alu & (~free_alu + 1'b1)) : '0;  // lowest free unit
    assign alu_issue.arg0 = op_a;
    assign alu_issue.arg1 = uses_rs2 ? op_b : r_instr.imm;
    assign alu_issue.cmd  = cmd;
    assign alu_issue.rd   = r_instr.rd;
    assign occupancy_lock = can_issue & (r_instr.rd != '0);  // x0 never waits
    assign occupancy_rd   = r_instr.rd;
    assign reg_ra0        = r_instr.rs1;
    assign reg_ra1        = r_instr.rs2;

endmodule

//--- rtl/occupancy_tracker.sv
// register scoreboard that marks destinations of in-flight instructions until their write-back
module occupancy_tracker #(
    parameter int NUM_ALU = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   lock,
    input  logic [core_config_pkg::REG_ADDR_W-1:0] lock_rd,
    input  core_config_pkg::wb_t [NUM_ALU-1:0]     wb,
    output logic [core_config_pkg::NUM_REGS-1:0]   busy
);
    import core_config_pkg::*;

    logic [NUM_REGS-1:0] r_lock;
    logic [NUM_REGS-1:0] set_mask;
    logic [NUM_REGS-1:0] clear_mask;

    always_comb begin
        set_mask   = '0;
        clear_mask = '0;
        if (lock) begin
            set_mask[lock_rd] = 1'b1;
        end
        for (int i = 0; i < NUM_ALU; i++) begin
            if (wb[i].valid) begin
                clear_mask[wb[i].rd] = 1'b1;
            end
        end
    end

    // a new lock wins over a release of the same register in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_lock <= '0;
        end else begin
            r_lock <= (r_lock & ~clear_mask) | set_mask;
        end
    end

    assign busy = r_lock;

endmodule

//--- rtl/reg_file.sv
// architectural register file with two asynchronous read ports and one write port per ALU
module reg_file #(
    parameter int NUM_ALU = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [core_config_pkg::REG_ADDR_W-1:0] ra0,
    input  logic [core_config_pkg::REG_ADDR_W-1:0] ra1,
    output logic [core_config_pkg::XLEN-1:0]       rd0,
    output logic [core_config_pkg::XLEN-1:0]       rd1,
    input  core_config_pkg::wb_t [NUM_ALU-1:0]     wb
);
    import core_config_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ALU; i++) begin
                if (wb[i].valid && wb[i].rd != '0) begin
                    regs[wb[i].rd] <= wb[i].data;  // x0 stays at its reset value
                end
            end
        end
    end

    assign rd0 = regs[ra0];
    assign rd1 = regs[ra1];

endmodule

//--- rtl/alu.sv
// two-cycle integer ALU that captures one operation on start and presents a single write-back
module alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  core_config_pkg::issue_t issue,
    output logic                    busy,
    output core_config_pkg::wb_t    wb
);
    import core_config_pkg::*;

    issue_t                  r_issue;
    logic                    r_run;
    logic                    r_valid;
    logic [REG_ADDR_W-1:0]   r_rd;
    logic [XLEN-1:0]         r_data;
    logic [XLEN-1:0]         a;
    logic [XLEN-1:0]         b;
    logic [$clog2(XLEN)-1:0] shamt;
    logic [XLEN-1:0]         result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_run   <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            r_run   <= start;  // first cycle holds the operands
            r_valid <= r_run;  // second cycle presents the result
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            r_issue <= issue;
        end
        if (r_run) begin
            r_rd   <= r_issue.rd;
            r_data <= result;
        end
    end

    assign a     = r_issue.arg0;
    assign b     = r_issue.arg1;
    assign shamt = b[$clog2(XLEN)-1:0];

    always_comb begin
        case (r_issue.cmd)
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            default:  result = a + b;
        endcase
    end

    assign busy = r_run | r_valid;  // free again once the write-back has gone
    assign wb   = '{valid: r_valid, rd: r_rd, data: r_data};

endmodule

//--- rtl/exec_core.sv
// top level of the execution slice, connecting decoder, issuer, scoreboard, registers and ALUs
module exec_core #(
    parameter int NUM_ALU = 2
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [core_config_pkg::XLEN-1:0]   instr,
    input  logic                               instr_valid,
    output logic                               instr_ready,
    output core_config_pkg::wb_t [NUM_ALU-1:0] retire,
    output logic                               illegal
);
    import core_config_pkg::*;

    decoded_t              dec;
    logic                  dec_valid;
    logic                  dec_busy;
    logic                  occ_lock;
    logic [REG_ADDR_W-1:0] occ_rd;
    logic [NUM_REGS-1:0]   occ_busy;
    logic [REG_ADDR_W-1:0] ra0;
    logic [REG_ADDR_W-1:0] ra1;
    logic [XLEN-1:0]       rd0;
    logic [XLEN-1:0]       rd1;
    logic [NUM_ALU-1:0]    alu_start;
    logic [NUM_ALU-1:0]    alu_busy;
    issue_t                alu_issue;

    assign instr_ready = ~dec_busy;

    // ==================================================
    // front end
    // ==================================================
    decoder u_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .dec_busy    (dec_busy),
        .dec         (dec),
        .dec_valid   (dec_valid)
    );

    issuer #(.NUM_ALU(NUM_ALU)) u_issuer (
        .clk            (clk),
        .rst_n          (rst_n),
        .dec            (dec),
        .dec_valid      (dec_valid),
        .dec_busy       (dec_busy),
        .occupancy_lock (occ_lock),
        .occupancy_rd   (occ_rd),
        .occupancy_busy (occ_busy),
        .reg_ra0        (ra0),
        .reg_ra1        (ra1),
        .reg_rd0        (rd0),
        .reg_rd1        (rd1),
        .bypass         (retire),
        .alu_start      (alu_start),
        .alu_issue      (alu_issue),
        .alu_busy       (alu_busy),
        .illegal        (illegal)
    );

    occupancy_tracker #(.NUM_ALU(NUM_ALU)) u_tracker (
        .clk     (clk),
        .rst_n   (rst_n),
        .lock    (occ_lock),
        .lock_rd (occ_rd),
        .wb      (retire),
        .busy    (occ_busy)
    );

    reg_file #(.NUM_ALU(NUM_ALU)) u_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .ra0   (ra0),
        .ra1   (ra1),
        .rd0   (rd0),
        .rd1   (rd1),
        .wb    (retire)
    );

    // ==================================================
    // ALU cluster, all units share the issue bus
    // ==================================================
    for (genvar i = 0; i < NUM_ALU; i++) begin : g_alu
        alu u_alu (
            .clk   (clk),
            .rst_n (rst_n),
            .start (alu_start[i]),
            .issue (alu_issue),
            .busy  (alu_busy[i]),
            .wb    (retire[i])
        );
    end

endmodule

//--- include/tb_model.svh
// reference model functions for the testbench covering instruction encoders, RV32I results and the LFSR
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// register-register arithmetic encoding
function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
endfunction

// register-immediate encoding where shifts carry funct7 in imm[11:5]
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] funct3,
                                      input logic [4:0] rd, input logic [4:0] rs1);
    return {imm, rs1, funct3, rd, 7'b0010011};
endfunction

// expected result of a legal instruction given its source register values
function automatic logic [31:0] model_result(input logic [31:0] instr, input logic [31:0] a,
                                             input logic [31:0] b_reg);
    logic        is_imm;
    logic [31:0] b;
    is_imm = ~instr[5];
    b      = is_imm ? {{20{instr[31]}}, instr[31:20]} : b_reg;
    case (instr[14:12])
        3'b000:  return (!is_imm && instr[30]) ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101: begin
            if (instr[30]) begin
                return $signed(a) >>> b[4:0];  // arithmetic shift keeps the sign
            end
            return a >> b[4:0];
        end
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// one Galois step of the x^32 + x^22 + x^2 + x + 1 sequence, shifting toward bit 0
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

`endif

//--- test/exec_core_tb.sv
// testbench for the execution slice that drives instruction streams and checks every write-back
module exec_core_tb;
    import core_config_pkg::*;

    `include "tb_model.svh"

    localparam int NUM_ALU = 2;
    localparam int TIMEOUT = 200;  // cycles allowed for any single wait

    logic                   clk;
    logic                   rst_n;
    logic [31:0]            instr;
    logic                   instr_valid;
    logic                   instr_ready;
    wb_t [NUM_ALU-1:0]      retire;
    logic                   illegal;
    logic [NUM_ALU-1:0]     retire_valid;

    logic [31:0] model_regs [32];  // architectural state in program order
    wb_t         exp_q [$];
    wb_t         exp_head;
    int          illegal_pending;
    logic [31:0] lfsr;
    logic        saw_stall;
    int          tests;
    int          checks;
    int          errors;
    int          checks_mark;
    int          errors_mark;

    exec_core #(.NUM_ALU(NUM_ALU)) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .retire      (retire),
        .illegal     (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always_comb begin
        for (int i = 0; i < NUM_ALU; i++) begin
            retire_valid[i] = retire[i].valid;
        end
    end

    // ==================================================
    // checkers
    // ==================================================
    // issue is one per cycle with a fixed latency, so write-backs never overlap
    a_one_retire: assert property (@(negedge clk) disable iff (!rst_n) $onehot0(retire_valid))
        else begin
            errors++;
            $display("more than one write-back in the same cycle at time %0t", $time);
        end

    always @(negedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < NUM_ALU; i++) begin
                if (retire[i].valid) begin
                    checks++;
                    assert (exp_q.size() > 0) else begin
                        errors++;
                        $display("write-back from ALU %0d with nothing outstanding at time %0t",
                                 i, $time);
                    end
                    if (exp_q.size() > 0) begin
                        exp_head = exp_q.pop_front();  // retire order is program order
                        assert (retire[i].rd == exp_head.rd && retire[i].data == exp_head.data)
                            else begin
                            errors++;
                            $display("MISMATCH at %0t: x%0d = %h, expected x%0d = %h", $time,
                                     retire[i].rd, retire[i].data, exp_head.rd, exp_head.data);
                        end
                    end
                end
            end
            if (illegal) begin
                checks++;
                assert (illegal_pending > 0) else begin
                    errors++;
                    $display("illegal pulsed with no illegal instruction sent at time %0t", $time);
                end
                if (illegal_pending > 0) begin
                    illegal_pending--;
                end
            end
            if (!instr_ready) begin
                saw_stall = 1'b1;
            end
        end
    end

    // ==================================================
    // stimulus helpers
    // ==================================================
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // legal OP or OP-IMM instruction over x0..x7
    function automatic logic [31:0] random_instr();
        logic        is_r;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        is_r = 1'(take_bits(1));
        f3   = 3'(take_bits(3));
        alt  = 1'(take_bits(1));
        rd   = 5'(take_bits(3));
        rs1  = 5'(take_bits(3));
        rs2  = 5'(take_bits(3));
        imm  = 12'(take_bits(12));
        if (is_r) begin
            return enc_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                         f3, rd, rs1, rs2);
        end
        if (f3 == 3'b001) begin
            imm[11:5] = 7'h00;
        end else if (f3 == 3'b101) begin
            imm[11:5] = alt ? 7'h20 : 7'h00;
        end
        return enc_i(imm, f3, rd, rs1);
    endfunction

    // called on a falling edge and returns on the falling edge after acceptance
    task automatic send_instr(input logic [31:0] ins, input logic legal);
        logic [31:0] res;
        int          cnt;
        if (legal) begin
            res = model_result(ins, model_regs[ins[19:15]], model_regs[ins[24:20]]);
            if (ins[11:7] != 5'd0) begin
                model_regs[ins[11:7]] = res;
            end
            exp_q.push_back('{valid: 1'b1, rd: ins[11:7], data: res});
        end else begin
            illegal_pending++;
        end
        instr       = ins;
        instr_valid = 1'b1;
        cnt         = 0;
        while (!instr_ready && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!instr_ready) begin
            errors++;
            $display("instr_ready stayed low for %0d cycles at time %0t", cnt, $time);
        end
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        while ((exp_q.size() != 0 || illegal_pending != 0) && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (exp_q.size() != 0 || illegal_pending != 0) begin
            errors++;
            $display("%0d write-backs and %0d illegal pulses never arrived", exp_q.size(),
                     illegal_pending);
            exp_q.delete();
            illegal_pending = 0;
        end
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);  // room for a stray or duplicate write-back
        end
    endtask

    task automatic run_single(input logic [31:0] ins);
        send_instr(ins, 1'b1);
        drain();
    endtask

    task automatic report(input string name);
        tests++;
        $display("test %-10s checks %0d errors %0d", name, checks - checks_mark,
                 errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        logic [11:0] imm;
        rst_n           = 1'b0;
        instr           = '0;
        instr_valid     = 1'b0;
        illegal_pending = 0;
        lfsr            = 32'h9582_af33;
        saw_stall       = 1'b0;
        tests           = 0;
        checks          = 0;
        errors          = 0;
        checks_mark     = 0;
        errors_mark     = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            checks++;
            assert (instr_ready) else begin
                errors++;
                $display("instr_ready low while idle after reset at time %0t", $time);
            end
        end
        report("reset");

        run_single(enc_i(12'h123, 3'b000, 5'd1, 5'd0));
        run_single(enc_i(12'hffb, 3'b000, 5'd2, 5'd0));
        for (int f = 0; f < 8; f++) begin
            run_single(enc_r(7'h00, f[2:0], 5'd3, 5'd1, 5'd2));
            if (f == 0 || f == 5) begin
                run_single(enc_r(7'h20, f[2:0], 5'd4, 5'd2, 5'd1));
            end
            imm = (f == 1 || f == 5) ? 12'h007 : 12'h8f1;
            run_single(enc_i(imm, f[2:0], 5'd5, 5'd2));
        end
        run_single(enc_i(12'h407, 3'b101, 5'd6, 5'd2));
        run_single(enc_i(12'h007, 3'b000, 5'd0, 5'd1));       // result goes to x0 and is discarded
        run_single(enc_r(7'h00, 3'b000, 5'd7, 5'd0, 5'd1));   // reads x0 back as zero
        report("single");

        send_instr(enc_i(12'h011, 3'b000, 5'd9, 5'd0), 1'b1);
        for (int k = 0; k < 8; k++) begin
            send_instr(enc_i(12'(k + 1), 3'b000, 5'd9, 5'd9), 1'b1);
            send_instr(enc_r(7'h00, 3'b000, 5'd10, 5'd9, 5'd10), 1'b1);
            send_instr(enc_r(7'h20, 3'b101, 5'd11, 5'd10, 5'd9), 1'b1);
        end
        drain();
        report("chain");

        saw_stall = 1'b0;
        for (int k = 0; k < 12; k++) begin
            send_instr(enc_i(12'(k * 3 + 1), 3'b000, 5'(12 + k), 5'd0), 1'b1);
        end
        drain();
        checks++;
        assert (saw_stall) else begin
            errors++;
            $display("instr_ready never dropped during the burst");
        end
        report("burst");

        send_instr(32'h0000_2083, 1'b0);                           // load word
        send_instr(enc_r(7'h01, 3'b000, 5'd1, 5'd1, 5'd2), 1'b0);  // multiply
        send_instr(enc_i(12'h407, 3'b001, 5'd3, 5'd1), 1'b0);      // shift left with funct7 set
        send_instr(enc_r(7'h00, 3'b000, 5'd24, 5'd1, 5'd2), 1'b1);
        drain();
        report("illegal");

        for (int k = 0; k < 200; k++) begin
            send_instr(random_instr(), 1'b1);
        end
        drain();
        report("random");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
rtl/core_config_pkg.sv
rtl/decoder.sv
rtl/issuer.sv
rtl/occupancy_tracker.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/exec_core.sv
test/exec_core_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module exec_core_tb -f tb.f \
    -o exec_core_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/exec_core_sim > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0
